//--- dual_issue_params.svh
/* Core sizes for the dual-issue retire path.
   DI_ROB_SLOTS must be a power of two and at least 2 */
`ifndef DUAL_ISSUE_PARAMS_SVH
`define DUAL_ISSUE_PARAMS_SVH

// Datapath width
`define DI_XLEN 32

// Architectural integer registers, x0 included
`define DI_NREGS 32

// Reorder buffer entries
`define DI_ROB_SLOTS 8

// Lane A registers after the ALU, fill comes out of the last one
`define DI_LANE_A_STAGES 3

`endif

//--- dual_issue_pkg.sv
/* Shared types and the integer ALU for the dual-issue retire path.
   Shifts use operand bits 4:0 only */
`default_nettype none
`include "dual_issue_params.svh"

package dual_issue_pkg;

  typedef logic [`DI_XLEN-1:0]              word_t;
  typedef logic [$clog2(`DI_NREGS)-1:0]     reg_idx_t;
  typedef logic [$clog2(`DI_ROB_SLOTS)-1:0] rob_slot_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
  } alu_fn_t;

  // Operand comes from the register file or a filled ROB slot
  typedef enum logic {
    SRC_RF,
    SRC_ROB
  } op_src_t;

  typedef struct packed {
    logic     valid;
    alu_fn_t  fn;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_imm;
    word_t    imm;
  } issue_op_t;

  // Op a is the older one
  typedef struct packed {
    issue_op_t a;
    issue_op_t b;
  } issue_bundle_t;

  // Index order is a.rs1, a.rs2, b.rs1, b.rs2
  typedef struct packed {
    op_src_t   [3:0] src;
    rob_slot_t [3:0] slot;
  } operand_sel_t;

  typedef struct packed {
    logic      valid;
    alu_fn_t   fn;
    word_t     op1;
    word_t     op2;
    rob_slot_t tag;
  } exec_op_t;

  typedef struct packed {
    logic      valid;
    rob_slot_t slot;
    word_t     result;
  } fill_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } commit_t;

  // First is the older commit
  typedef struct packed {
    commit_t first;
    commit_t second;
  } commit_pair_t;

  function automatic word_t alu_compute(alu_fn_t fn, word_t x, word_t y);
    case (fn)
      ADD:     return x + y;
      SUB:     return x - y;
      AND:     return x & y;
      OR:      return x | y;
      XOR:     return x ^ y;
      SLT:     return word_t'($signed(x) < $signed(y));
      SLTU:    return word_t'(x < y);
      SLL:     return x << y[4:0];
      SRL:     return x >> y[4:0];
      SRA:     return word_t'($signed(x) >>> y[4:0]);
      default: return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- reg_file.sv
/* Architectural registers with no reset value, write before reading.
   x0 reads as zero; the second commit wins on a shared rd */
`timescale 1ns/10ps
`default_nettype none
`include "dual_issue_params.svh"

module reg_file (
  input  wire                          clk,
  input  wire dual_issue_pkg::reg_idx_t raddr [4],
  output dual_issue_pkg::word_t        rdata [4],
  input  wire dual_issue_pkg::commit_pair_t commit_pair
);

  dual_issue_pkg::word_t mem [`DI_NREGS];

  // The registered commit lands in the array one edge later
  // so reads take it from the commit pair in between
  function automatic dual_issue_pkg::word_t pick(dual_issue_pkg::commit_pair_t cp,
                                                 dual_issue_pkg::reg_idx_t a,
                                                 dual_issue_pkg::word_t stored);
    if (a == '0) return '0;
    if (cp.second.valid && cp.second.rd == a) return cp.second.data;
    if (cp.first.valid && cp.first.rd == a) return cp.first.data;
    return stored;
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rdata[i] = pick(commit_pair, raddr[i], mem[raddr[i]]);
    end
  end

  always_ff @(posedge clk) begin
    if (commit_pair.first.valid && commit_pair.first.rd != '0) begin
      mem[commit_pair.first.rd] <= commit_pair.first.data;
    end
    if (commit_pair.second.valid && commit_pair.second.rd != '0) begin
      mem[commit_pair.second.rd] <= commit_pair.second.data;
    end
  end

endmodule

`default_nettype wire

//--- rob_data.sv
/* Reorder buffer payload, two fill writes and six read ports.
   A fill is readable while it is presented, before the array holds it */
`timescale 1ns/10ps
`default_nettype none
`include "dual_issue_params.svh"

module rob_data (
  input  wire                            clk,
  input  wire dual_issue_pkg::fill_t     fill_a,
  input  wire dual_issue_pkg::fill_t     fill_b,
  input  wire dual_issue_pkg::rob_slot_t rd_slot [4],
  output dual_issue_pkg::word_t          rd_data [4],
  input  wire dual_issue_pkg::rob_slot_t commit_slot_0,
  input  wire dual_issue_pkg::rob_slot_t commit_slot_1,
  output dual_issue_pkg::word_t          commit_data_0,
  output dual_issue_pkg::word_t          commit_data_1
);

  dual_issue_pkg::word_t mem [`DI_ROB_SLOTS];

  // Lanes never fill the same slot in one cycle
  function automatic dual_issue_pkg::word_t pick(dual_issue_pkg::fill_t fa,
                                                 dual_issue_pkg::fill_t fb,
                                                 dual_issue_pkg::rob_slot_t s,
                                                 dual_issue_pkg::word_t stored);
    if (fa.valid && fa.slot == s) return fa.result;
    if (fb.valid && fb.slot == s) return fb.result;
    return stored;
  endfunction

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rd_data[i] = pick(fill_a, fill_b, rd_slot[i], mem[rd_slot[i]]);
    end
  end

  assign commit_data_0 = pick(fill_a, fill_b, commit_slot_0, mem[commit_slot_0]);
  assign commit_data_1 = pick(fill_a, fill_b, commit_slot_1, mem[commit_slot_1]);

  always_ff @(posedge clk) begin
    if (fill_a.valid) begin
      mem[fill_a.slot] <= fill_a.result;
    end
    if (fill_b.valid) begin
      mem[fill_b.slot] <= fill_b.result;
    end
  end

endmodule

`default_nettype wire

//--- rob_control.sv
/* ROB slot allocation, rename table, operand sourcing and in-order commit.
   Issue needs two free slots and no pending source; b is never valid without a */
`timescale 1ns/10ps
`default_nettype none
`include "dual_issue_params.svh"

module rob_control (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                issue_val,
  input  wire dual_issue_pkg::issue_bundle_t issue_bundle,
  output logic                               issue_rdy,
  output dual_issue_pkg::operand_sel_t       operand_sel,
  output dual_issue_pkg::rob_slot_t          slot_a,
  output dual_issue_pkg::rob_slot_t          slot_b,
  input  wire dual_issue_pkg::fill_t         fill_a,
  input  wire dual_issue_pkg::fill_t         fill_b,
  output dual_issue_pkg::rob_slot_t          commit_slot_0,
  output dual_issue_pkg::rob_slot_t          commit_slot_1,
  input  wire dual_issue_pkg::word_t         commit_data_0,
  input  wire dual_issue_pkg::word_t         commit_data_1,
  output dual_issue_pkg::commit_pair_t       commit_pair
);

  localparam int SLOTS = `DI_ROB_SLOTS;
  localparam int CW = $clog2(`DI_ROB_SLOTS) + 1;

  dual_issue_pkg::issue_op_t ops [2];
  dual_issue_pkg::rob_slot_t alloc_slot [2];
  dual_issue_pkg::rob_slot_t head;
  dual_issue_pkg::rob_slot_t tail;
  logic [CW-1:0]             used;
  logic [CW-1:0]             n_alloc;
  logic [CW-1:0]             n_commit;
  logic [SLOTS-1:0]          filled;
  logic [SLOTS-1:0]          filled_now;
  dual_issue_pkg::reg_idx_t  slot_rd [SLOTS];
  logic [`DI_NREGS-1:0]      map_valid;
  dual_issue_pkg::rob_slot_t map_slot [`DI_NREGS];
  logic                      pending;
  logic                      accept;
  logic [1:0]                alloc;
  logic                      commit_0;
  logic                      commit_1;

  assign ops[0] = issue_bundle.a;
  assign ops[1] = issue_bundle.b;

  // A slot counts as filled while its fill is presented
  always_comb begin
    filled_now = filled;
    if (fill_a.valid) begin
      filled_now[fill_a.slot] = 1'b1;
    end
    if (fill_b.valid) begin
      filled_now[fill_b.slot] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Operand source and issue hold
  // --------------------------------------------------

  // Both ops look up the table as it was before the bundle
  always_comb begin
    dual_issue_pkg::reg_idx_t rs;
    logic reads;
    pending = 1'b0;
    for (int i = 0; i < 4; i++) begin
      rs = i[0] ? ops[i/2].rs2 : ops[i/2].rs1;
      reads = ops[i/2].valid && rs != '0 && !(i[0] && ops[i/2].use_imm);
      operand_sel.slot[i] = map_slot[rs];
      if (map_valid[rs]) begin
        operand_sel.src[i] = dual_issue_pkg::SRC_ROB;
      end else begin
        operand_sel.src[i] = dual_issue_pkg::SRC_RF;
      end
      if (reads && map_valid[rs] && !filled_now[map_slot[rs]]) begin
        pending = 1'b1;
      end
    end
  end

  assign issue_rdy = (used <= CW'(SLOTS - 2)) && !pending;
  assign accept = issue_val && issue_rdy;
  assign alloc = {ops[1].valid, ops[0].valid} & {2{accept}};
  assign n_alloc = CW'(alloc[0]) + CW'(alloc[1]);

  assign slot_a = tail;
  assign slot_b = tail + 1'b1;
  assign alloc_slot[0] = slot_a;
  assign alloc_slot[1] = slot_b;

  // --------------------------------------------------
  // Commit from the head, oldest first
  // --------------------------------------------------

  assign commit_slot_0 = head;
  assign commit_slot_1 = head + 1'b1;
  assign commit_0 = (used != '0) && filled_now[commit_slot_0];
  assign commit_1 = commit_0 && (used > CW'(1)) && filled_now[commit_slot_1];
  assign n_commit = CW'(commit_0) + CW'(commit_1);

  always_ff @(posedge clk) begin
    commit_pair.first <= '{valid: commit_0, rd: slot_rd[commit_slot_0], data: commit_data_0};
    commit_pair.second <= '{valid: commit_1, rd: slot_rd[commit_slot_1], data: commit_data_1};
    if (reset) begin
      head <= '0;
      tail <= '0;
      used <= '0;
      filled <= '0;
      map_valid <= '0;
      commit_pair.first.valid <= 1'b0;
      commit_pair.second.valid <= 1'b0;
    end else begin
      head <= head + dual_issue_pkg::rob_slot_t'(n_commit);
      tail <= tail + dual_issue_pkg::rob_slot_t'(n_alloc);
      used <= used + n_alloc - n_commit;
      filled <= filled_now;
      // Release the mapping only if no younger slot has taken the register
      if (commit_0 && map_slot[slot_rd[commit_slot_0]] == commit_slot_0) begin
        map_valid[slot_rd[commit_slot_0]] <= 1'b0;
      end
      if (commit_1 && map_slot[slot_rd[commit_slot_1]] == commit_slot_1) begin
        map_valid[slot_rd[commit_slot_1]] <= 1'b0;
      end
      // New mappings override the releases, b after a
      for (int i = 0; i < 2; i++) begin
        if (alloc[i]) begin
          filled[alloc_slot[i]] <= 1'b0;
          slot_rd[alloc_slot[i]] <= ops[i].rd;
          if (ops[i].rd != '0) begin
            map_valid[ops[i].rd] <= 1'b1;
            map_slot[ops[i].rd] <= alloc_slot[i];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- operand_select.sv
/* Operand muxing and the execute input register for both lanes.
   An immediate replaces the second operand; valids drop when accept is low */
`timescale 1ns/10ps
`default_nettype none

module operand_select (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                accept,
  input  wire dual_issue_pkg::issue_bundle_t issue_bundle,
  input  wire dual_issue_pkg::operand_sel_t  operand_sel,
  input  wire dual_issue_pkg::rob_slot_t     slot_a,
  input  wire dual_issue_pkg::rob_slot_t     slot_b,
  input  wire dual_issue_pkg::word_t         rf_data [4],
  input  wire dual_issue_pkg::word_t         rob_rd_data [4],
  output dual_issue_pkg::reg_idx_t           rf_addr [4],
  output dual_issue_pkg::rob_slot_t          rob_rd_slot [4],
  output dual_issue_pkg::exec_op_t           exec_a,
  output dual_issue_pkg::exec_op_t           exec_b
);

  dual_issue_pkg::issue_op_t ops [2];
  dual_issue_pkg::word_t     opnd [4];
  dual_issue_pkg::exec_op_t  next_op [2];

  assign ops[0] = issue_bundle.a;
  assign ops[1] = issue_bundle.b;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rf_addr[i] = i[0] ? ops[i/2].rs2 : ops[i/2].rs1;
      rob_rd_slot[i] = operand_sel.slot[i];
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (operand_sel.src[i] == dual_issue_pkg::SRC_ROB) begin
        opnd[i] = rob_rd_data[i];
      end else begin
        opnd[i] = rf_data[i];
      end
    end
    for (int l = 0; l < 2; l++) begin
      next_op[l].valid = accept && ops[l].valid;
      next_op[l].fn = ops[l].fn;
      next_op[l].op1 = opnd[2*l];
      next_op[l].op2 = ops[l].use_imm ? ops[l].imm : opnd[2*l+1];
    end
    next_op[0].tag = slot_a;
    next_op[1].tag = slot_b;
  end

  always_ff @(posedge clk) begin
    exec_a <= next_op[0];
    exec_b <= next_op[1];
    if (reset) begin
      exec_a.valid <= 1'b0;
      exec_b.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- exec_lanes.sv
/* Lane A fills DI_LANE_A_STAGES edges after its execute input, lane B after one.
   No stalls; up to DI_LANE_A_STAGES lane A ops can be in flight */
`timescale 1ns/10ps
`default_nettype none
`include "dual_issue_params.svh"

module exec_lanes (
  input  wire                           clk,
  input  wire                           reset,
  input  wire dual_issue_pkg::exec_op_t exec_a,
  input  wire dual_issue_pkg::exec_op_t exec_b,
  output dual_issue_pkg::fill_t         fill_a,
  output dual_issue_pkg::fill_t         fill_b
);

  localparam int DEPTH = `DI_LANE_A_STAGES;

  dual_issue_pkg::word_t result_a;
  dual_issue_pkg::word_t result_b;
  dual_issue_pkg::fill_t lane_a [DEPTH];

  assign result_a = dual_issue_pkg::alu_compute(exec_a.fn, exec_a.op1, exec_a.op2);
  assign result_b = dual_issue_pkg::alu_compute(exec_b.fn, exec_b.op1, exec_b.op2);

  // --------------------------------------------------
  // Lane B, single stage
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    fill_b <= '{valid: exec_b.valid, slot: exec_b.tag, result: result_b};
    if (reset) begin
      fill_b.valid <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Lane A, result carried down the stage chain
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    lane_a[0] <= '{valid: exec_a.valid, slot: exec_a.tag, result: result_a};
    for (int i = 1; i < DEPTH; i++) begin
      lane_a[i] <= lane_a[i-1];
    end
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        lane_a[i].valid <= 1'b0;
      end
    end
  end

  assign fill_a = lane_a[DEPTH-1];

endmodule

`default_nettype wire

//--- dual_issue_core.sv
/* Dual-issue retire path top. A bundle is taken when issue_val and issue_rdy
   are both high; commits have no back-pressure */
`timescale 1ns/10ps
`default_nettype none

module dual_issue_core (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                issue_val,
  input  wire dual_issue_pkg::issue_bundle_t issue_bundle,
  output logic                               issue_rdy,
  output dual_issue_pkg::commit_pair_t       commit_pair
);

  logic                         accept;
  dual_issue_pkg::operand_sel_t operand_sel;
  dual_issue_pkg::rob_slot_t    slot_a;
  dual_issue_pkg::rob_slot_t    slot_b;
  dual_issue_pkg::fill_t        fill_a;
  dual_issue_pkg::fill_t        fill_b;
  dual_issue_pkg::rob_slot_t    commit_slot_0;
  dual_issue_pkg::rob_slot_t    commit_slot_1;
  dual_issue_pkg::word_t        commit_data_0;
  dual_issue_pkg::word_t        commit_data_1;
  dual_issue_pkg::word_t        rf_data [4];
  dual_issue_pkg::word_t        rob_rd_data [4];
  dual_issue_pkg::reg_idx_t     rf_addr [4];
  dual_issue_pkg::rob_slot_t    rob_rd_slot [4];
  dual_issue_pkg::exec_op_t     exec_a;
  dual_issue_pkg::exec_op_t     exec_b;

  // Issue handshake
  assign accept = issue_val & issue_rdy;

  rob_control i_rob_control (
    .clk           (clk),
    .reset         (reset),
    .issue_val     (issue_val),
    .issue_bundle  (issue_bundle),
    .issue_rdy     (issue_rdy),
    .operand_sel   (operand_sel),
    .slot_a        (slot_a),
    .slot_b        (slot_b),
    .fill_a        (fill_a),
    .fill_b        (fill_b),
    .commit_slot_0 (commit_slot_0),
    .commit_slot_1 (commit_slot_1),
    .commit_data_0 (commit_data_0),
    .commit_data_1 (commit_data_1),
    .commit_pair   (commit_pair)
  );

  operand_select i_operand_select (
    .clk          (clk),
    .reset        (reset),
    .accept       (accept),
    .issue_bundle (issue_bundle),
    .operand_sel  (operand_sel),
    .slot_a       (slot_a),
    .slot_b       (slot_b),
    .rf_data      (rf_data),
    .rob_rd_data  (rob_rd_data),
    .rf_addr      (rf_addr),
    .rob_rd_slot  (rob_rd_slot),
    .exec_a       (exec_a),
    .exec_b       (exec_b)
  );

  exec_lanes i_exec_lanes (
    .clk    (clk),
    .reset  (reset),
    .exec_a (exec_a),
    .exec_b (exec_b),
    .fill_a (fill_a),
    .fill_b (fill_b)
  );

  rob_data i_rob_data (
    .clk           (clk),
    .fill_a        (fill_a),
    .fill_b        (fill_b),
    .rd_slot       (rob_rd_slot),
    .rd_data       (rob_rd_data),
    .commit_slot_0 (commit_slot_0),
    .commit_slot_1 (commit_slot_1),
    .commit_data_0 (commit_data_0),
    .commit_data_1 (commit_data_1)
  );

  reg_file i_reg_file (
    .clk         (clk),
    .raddr       (rf_addr),
    .rdata       (rf_data),
    .commit_pair (commit_pair)
  );

endmodule

`default_nettype wire

//--- tb_dual_issue_core.sv
/* Directed tests for the dual-issue retire path against a register model.
   Registers are written by an init pass before any test reads them */
`timescale 1ns/10ps
`default_nettype none
`include "dual_issue_params.svh"

module tb_dual_issue_core;

  // Bundles sent per test: init, alu, order, raw, same-bundle, random
  localparam int BUNDLES = 16 + 23 + 5 + 5 + 3 + 200;
  localparam int LIMIT = BUNDLES * 12 + 200;

  logic                          clk;
  logic                          reset;
  logic                          issue_val;
  dual_issue_pkg::issue_bundle_t issue_bundle;
  logic                          issue_rdy;
  dual_issue_pkg::commit_pair_t  commit_pair;

  logic [31:0] model_regs [`DI_NREGS];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] rng = 32'ha3bd_0184;
  string       test_name = "none";
  int          errors = 0;
  int          commit_count = 0;
  int          op_count = 0;
  int          stalls = 0;
  int          cycles = 0;

  dual_issue_core i_dual_issue_core (
    .clk          (clk),
    .reset        (reset),
    .issue_val    (issue_val),
    .issue_bundle (issue_bundle),
    .issue_rdy    (issue_rdy),
    .commit_pair  (commit_pair)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles with %0d commits outstanding", cycles, exp_rd.size());
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] ref_alu(dual_issue_pkg::alu_fn_t fn, logic [31:0] x,
                                          logic [31:0] y);
    logic [4:0] sh;
    sh = y[4:0];
    case (fn)
      dual_issue_pkg::ADD:  return x + y;
      dual_issue_pkg::SUB:  return x - y;
      dual_issue_pkg::AND:  return x & y;
      dual_issue_pkg::OR:   return x | y;
      dual_issue_pkg::XOR:  return x ^ y;
      dual_issue_pkg::SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      dual_issue_pkg::SLTU: return (x < y) ? 32'd1 : 32'd0;
      dual_issue_pkg::SLL:  return x << sh;
      dual_issue_pkg::SRL:  return x >> sh;
      dual_issue_pkg::SRA:  return 32'($signed(x) >>> sh);
      default:              return 32'd0;
    endcase
  endfunction

  function automatic dual_issue_pkg::issue_op_t make_op(dual_issue_pkg::alu_fn_t fn,
      logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2, logic use_imm, logic [31:0] imm);
    dual_issue_pkg::issue_op_t op;
    op.valid = 1'b1;
    op.fn = fn;
    op.rd = rd;
    op.rs1 = rs1;
    op.rs2 = rs2;
    op.use_imm = use_imm;
    op.imm = imm;
    return op;
  endfunction

  // Both ops read the state before the bundle, then b's write lands last
  task automatic push_model(input dual_issue_pkg::issue_bundle_t bnd);
    dual_issue_pkg::issue_op_t op [2];
    logic [31:0] res [2];
    op[0] = bnd.a;
    op[1] = bnd.b;
    for (int i = 0; i < 2; i++) begin
      res[i] = ref_alu(op[i].fn, model_regs[op[i].rs1],
                       op[i].use_imm ? op[i].imm : model_regs[op[i].rs2]);
    end
    for (int i = 0; i < 2; i++) begin
      if (op[i].valid) begin
        exp_rd.push_back(op[i].rd);
        exp_data.push_back(res[i]);
        op_count++;
        if (op[i].rd != 5'd0) model_regs[op[i].rd] = res[i];
      end
    end
  endtask

  // --------------------------------------------------
  // Issue driver and commit checker
  // --------------------------------------------------

  task automatic send_bundle(input dual_issue_pkg::issue_bundle_t bnd);
    logic rdy;
    stalls = 0;
    rdy = 1'b0;
    @(negedge clk);
    issue_val = 1'b1;
    issue_bundle = bnd;
    while (!rdy) begin
      #10;
      rdy = issue_rdy;
      @(posedge clk);
      if (!rdy) begin
        stalls++;
        @(negedge clk);
      end
    end
    push_model(bnd);
  endtask

  task automatic drain();
    @(negedge clk);
    issue_val = 1'b0;
    while (exp_rd.size() != 0) @(posedge clk);
  endtask

  task automatic check_commit(input dual_issue_pkg::commit_t c);
    logic [4:0]  erd;
    logic [31:0] edata;
    commit_count++;
    if (exp_rd.size() == 0) begin
      $display("%s: commit to x%0d arrived with no op outstanding", test_name, c.rd);
      errors++;
    end else begin
      erd = exp_rd.pop_front();
      edata = exp_data.pop_front();
      if (c.rd != erd || c.data != edata) begin
        $display("ERR %s: expected x%0d=%h, got x%0d=%h", test_name, erd, edata, c.rd, c.data);
        errors++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (commit_pair.second.valid && !commit_pair.first.valid) begin
        $display("%s: second commit valid without the first", test_name);
        errors++;
      end
      if (commit_pair.first.valid) check_commit(commit_pair.first);
      if (commit_pair.second.valid) check_commit(commit_pair.second);
    end
  end

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic reset_state();
    test_name = "reset_state";
    #10;
    if (commit_pair.first.valid !== 1'b0 || commit_pair.second.valid !== 1'b0) begin
      $display("ERR %s: expected commit valids 0/0, got %b/%b", test_name,
               commit_pair.first.valid, commit_pair.second.valid);
      errors++;
    end
    if (issue_rdy !== 1'b1) begin
      $display("ERR %s: expected issue_rdy 1, got %b", test_name, issue_rdy);
      errors++;
    end
  endtask

  task automatic init_regs();
    dual_issue_pkg::issue_bundle_t bnd;
    test_name = "init_regs";
    for (int r = 1; r < 32; r += 2) begin
      bnd.a = make_op(dual_issue_pkg::ADD, 5'(r), 5'd0, 5'd0, 1'b1, next_rand());
      bnd.b = make_op(dual_issue_pkg::ADD, 5'(r + 1), 5'd0, 5'd0, 1'b1, next_rand());
      bnd.b.valid = (r < 31);
      send_bundle(bnd);
    end
    drain();
  endtask

  task automatic alu_ops();
    dual_issue_pkg::issue_bundle_t bnd;
    dual_issue_pkg::alu_fn_t fn;
    test_name = "alu_ops";
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd1, 5'd0, 5'd0, 1'b1, 32'hffff_fffb);
    bnd.b = make_op(dual_issue_pkg::ADD, 5'd2, 5'd0, 5'd0, 1'b1, 32'd3);
    send_bundle(bnd);
    for (int i = 0; i < 10; i++) begin
      fn = dual_issue_pkg::alu_fn_t'(i);
      bnd.a = make_op(fn, 5'd20, 5'd1, 5'd2, 1'b0, 32'd0);
      bnd.b = make_op(fn, 5'd21, 5'd1, 5'd0, 1'b1, 32'h8000_0023);
      send_bundle(bnd);
      bnd.a = make_op(fn, 5'd22, 5'd2, 5'd0, 1'b1, 32'hffff_ff81);
      bnd.b = make_op(fn, 5'd23, 5'd2, 5'd1, 1'b0, 32'd0);
      send_bundle(bnd);
    end
    // x1 = -5 and x2 = 3, results known up front
    bnd.a = make_op(dual_issue_pkg::SLT, 5'd24, 5'd1, 5'd2, 1'b0, 32'd0);
    bnd.b = make_op(dual_issue_pkg::SLTU, 5'd25, 5'd1, 5'd2, 1'b0, 32'd0);
    send_bundle(bnd);
    exp_data[exp_data.size()-2] = 32'd1;
    exp_data[exp_data.size()-1] = 32'd0;
    bnd.a = make_op(dual_issue_pkg::SRA, 5'd26, 5'd1, 5'd0, 1'b1, 32'd1);
    bnd.b = make_op(dual_issue_pkg::SRL, 5'd27, 5'd1, 5'd0, 1'b1, 32'd1);
    send_bundle(bnd);
    exp_data[exp_data.size()-2] = 32'hffff_fffd;
    exp_data[exp_data.size()-1] = 32'h7fff_fffd;
    drain();
  endtask

  // Younger lane B results fill before the older lane A result
  task automatic in_order_commit();
    dual_issue_pkg::issue_bundle_t bnd;
    test_name = "in_order_commit";
    bnd.a = make_op(dual_issue_pkg::SLL, 5'd16, 5'd3, 5'd0, 1'b1, 32'd4);
    bnd.b = '0;
    send_bundle(bnd);
    for (int i = 0; i < 4; i++) begin
      bnd.a = make_op(dual_issue_pkg::XOR, 5'(17 + i), 5'd4, 5'd5, 1'b0, 32'd0);
      bnd.b = make_op(dual_issue_pkg::ADD, 5'(28 + i), 5'd6, 5'd0, 1'b1, 32'(i));
      send_bundle(bnd);
    end
    drain();
  endtask

  task automatic raw_chain();
    dual_issue_pkg::issue_bundle_t bnd;
    test_name = "raw_chain";
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd5, 5'd1, 5'd2, 1'b0, 32'd0);
    bnd.b = '0;
    send_bundle(bnd);
    bnd.a = make_op(dual_issue_pkg::XOR, 5'd6, 5'd3, 5'd0, 1'b1, 32'h5a5a_0f0f);
    bnd.b = make_op(dual_issue_pkg::SUB, 5'd7, 5'd5, 5'd4, 1'b0, 32'd0);
    send_bundle(bnd);
    if (stalls == 0) begin
      $display("%s: issue_rdy stayed high while x5 was pending", test_name);
      errors++;
    end
    bnd.a = make_op(dual_issue_pkg::OR, 5'd8, 5'd7, 5'd6, 1'b0, 32'd0);
    bnd.b = '0;
    send_bundle(bnd);
    if (stalls == 0) begin
      $display("%s: issue_rdy stayed high while x6 and x7 were pending", test_name);
      errors++;
    end
    drain();
    // Write to x0 is dropped so the next bundle still reads zero
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd0, 5'd1, 5'd0, 1'b1, 32'd9);
    bnd.b = '0;
    send_bundle(bnd);
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd11, 5'd0, 5'd0, 1'b1, 32'd7);
    bnd.b = make_op(dual_issue_pkg::ADD, 5'd10, 5'd0, 5'd0, 1'b0, 32'd0);
    send_bundle(bnd);
    if (stalls != 0) begin
      $display("%s: issue held on a bundle that reads x0 after a write to x0", test_name);
      errors++;
    end
    drain();
  endtask

  task automatic same_bundle_rules();
    dual_issue_pkg::issue_bundle_t bnd;
    test_name = "same_bundle_rules";
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd12, 5'd1, 5'd0, 1'b1, 32'd100);
    bnd.b = make_op(dual_issue_pkg::ADD, 5'd13, 5'd12, 5'd0, 1'b1, 32'd0);
    send_bundle(bnd);
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd14, 5'd2, 5'd0, 1'b1, 32'd1);
    bnd.b = make_op(dual_issue_pkg::SUB, 5'd14, 5'd3, 5'd4, 1'b0, 32'd0);
    send_bundle(bnd);
    bnd.a = make_op(dual_issue_pkg::ADD, 5'd15, 5'd14, 5'd0, 1'b1, 32'd0);
    bnd.b = '0;
    send_bundle(bnd);
    drain();
  endtask

  task automatic random_stream();
    dual_issue_pkg::issue_bundle_t bnd;
    logic [31:0] r1;
    logic [31:0] r2;
    test_name = "random_stream";
    for (int n = 0; n < 200; n++) begin
      r1 = next_rand();
      r2 = next_rand();
      bnd.a = make_op(dual_issue_pkg::alu_fn_t'(r1[3:0] % 10), r1[8:4], r1[13:9],
                      r1[18:14], r1[19], next_rand());
      bnd.b = make_op(dual_issue_pkg::alu_fn_t'(r2[3:0] % 10), r2[8:4], r2[13:9],
                      r2[18:14], r2[19], next_rand());
      bnd.a.valid = (r1[31:29] != 3'd0);
      bnd.b.valid = bnd.a.valid && (r2[31:30] != 2'd0);
      send_bundle(bnd);
    end
    drain();
    if (commit_count != op_count) begin
      $display("ERR %s: expected %0d commits, got %0d", test_name, op_count, commit_count);
      errors++;
    end
  endtask

  initial begin
    reset = 1'b1;
    issue_val = 1'b0;
    issue_bundle = '0;
    model_regs[0] = 32'd0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_state();
    init_regs();
    alu_ops();
    in_order_commit();
    raw_chain();
    same_bundle_rules();
    random_stream();
    $display("Errors: %0d  commits: %0d  ops issued: %0d", errors, commit_count, op_count);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
dual_issue_pkg.sv
reg_file.sv
rob_data.sv
rob_control.sv
operand_select.sv
exec_lanes.sv
dual_issue_core.sv
tb_dual_issue_core.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_dual_issue_core \
  -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
